/* Makefile */
SIM  := obj_dir/Vdecomp_unit_tb
SRCS := $(shell grep -v '^+' build.f)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): build.f $(SRCS)
	verilator --binary --timing --assert -f build.f --top-module decomp_unit_tb -Mdir obj_dir

# the run passes only if the log holds the pass line
run: $(SIM)
	./$(SIM) | tee sim.log
	grep -qx "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* build.f */
source/decomp_pkg.sv
source/delay_line.sv
source/elem_decomp.sv
source/decomp_ctrl.sv
source/decomp_unit.sv
tests/decomp_unit_sva.sv
tests/decomp_unit_tb.sv

/* source/decomp_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module decomp_ctrl (
  input  wire logic                                            clk,
  input  wire logic                                            arst_n,
  input  wire logic                                            cfg_load,
  input  wire decomp_pkg::decomp_cfg_t                         cfg,
  input  wire logic                                            in_valid,
  input  wire logic                                            out_valid,
  output decomp_pkg::lane_ctl_t [decomp_pkg::NUM_LANES-1:0]    lane_ctl,
  output logic                                                 cfg_busy,
  output logic                                                 cfg_reject
);

  import decomp_pkg::*;

  // number of coefficients between the input and the output
  logic [FLIGHT_W-1:0] in_flight;

  // product of digit width and digit count, must not pass the coefficient width
  logic [CNT_W+LEVELS_W-1:0] cfg_prod;

  // the requested setting is legal on its own
  logic cfg_ok;

  // the request is legal and the pipeline is quiet
  logic cfg_accept;

  // lane words that an accepted setting would produce
  lane_ctl_t [NUM_LANES-1:0] lane_ctl_next;

  // builds the control word of one lane from a setting
  function automatic lane_ctl_t make_lane_ctl(decomp_cfg_t c, int unsigned idx);
    lane_ctl_t lc;
    // digit idx starts idx digit widths above bit 0
    lc.shift   = CNT_W'(idx * c.base_bits);
    lc.bit_cnt = c.base_bits;
    // only the first levels lanes produce digits
    lc.enable  = (idx < c.levels);
    return lc;
  endfunction

  assign cfg_prod = cfg.base_bits * cfg.levels;

  always_comb begin
    cfg_ok = (cfg.base_bits != '0) && (cfg.base_bits <= MAX_BASE_BITS) &&
             (cfg.levels != '0) && (cfg.levels <= NUM_LANES) &&
             (cfg_prod <= COEFF_W);
    // a change with words in flight would mix two settings in one burst,
    // and an input in the load cycle would still see the old lane words
    cfg_accept = cfg_load && cfg_ok && !cfg_busy && !in_valid;
  end

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_ctl_next[i] = make_lane_ctl(cfg, i);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        lane_ctl[i] <= make_lane_ctl(DEFAULT_CFG, i);
      end
      cfg_reject <= 1'b0;
    end else begin
      // new lane words are seen by coefficients from the next cycle on
      if (cfg_accept) begin
        lane_ctl <= lane_ctl_next;
      end
      // every refused load gives one pulse, the old words stay put
      cfg_reject <= cfg_load && !cfg_accept;
    end
  end

  // counts up per input and down per output, both in one cycle leave it alone
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      in_flight <= '0;
    end else begin
      case ({in_valid, out_valid})
        2'b10:   in_flight <= in_flight + 1'b1;
        2'b01:   in_flight <= in_flight - 1'b1;
        default: in_flight <= in_flight;
      endcase
    end
  end

  // high from the cycle after an input until the cycle after its output
  assign cfg_busy = (in_flight != '0);

endmodule

`default_nettype wire

/* source/decomp_pkg.sv */
`default_nettype none

package decomp_pkg;

  // width of one ciphertext coefficient
  localparam int unsigned COEFF_W = 64;

  // one lane per digit, so this is also the largest number of levels
  localparam int unsigned NUM_LANES = 4;

  // shift and bit-count fields, wide enough to hold 64 and the largest lane shift of 96
  localparam int unsigned CNT_W = 7;

  // width of the levels field in the setting
  localparam int unsigned LEVELS_W = 3;

  // widest digit that a setting may ask for
  localparam int unsigned MAX_BASE_BITS = 32;

  // shift and mask paths are carried this many cycles before the AND
  localparam int unsigned SHIFT_STAGES = 4;

  // one more register after the AND gives the full input to output delay
  localparam int unsigned DECOMP_LATENCY = SHIFT_STAGES + 1;

  // in-flight counter must reach DECOMP_LATENCY with back-to-back input
  localparam int unsigned FLIGHT_W = $clog2(DECOMP_LATENCY + 1);

  // decomposition setting as loaded by the host
  typedef struct packed {
    logic [CNT_W-1:0]    base_bits;
    logic [LEVELS_W-1:0] levels;
  } decomp_cfg_t;

  // per-lane control word driven by the control block
  typedef struct packed {
    logic [CNT_W-1:0] shift;
    logic [CNT_W-1:0] bit_cnt;
    logic             enable;
  } lane_ctl_t;

  // all digits of one coefficient together with their valid bits
  typedef struct packed {
    logic [NUM_LANES-1:0][COEFF_W-1:0] digits;
    logic [NUM_LANES-1:0]              lane_valid;
  } digit_bundle_t;

  // setting after reset gives four 16-bit digits
  localparam decomp_cfg_t DEFAULT_CFG = '{base_bits: 7'd16, levels: 3'd4};

endpackage

`default_nettype wire

/* source/decomp_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module decomp_unit (
  input  wire logic                           clk,
  input  wire logic                           arst_n,
  input  wire logic                           cfg_load,
  input  wire decomp_pkg::decomp_cfg_t        cfg,
  input  wire logic                           in_valid,
  input  wire logic                           in_last,
  input  wire logic [decomp_pkg::COEFF_W-1:0] coeff,
  output logic                                out_valid,
  output logic                                out_last,
  output decomp_pkg::digit_bundle_t           out,
  output logic                                cfg_busy,
  output logic                                cfg_reject
);

  import decomp_pkg::*;

  // control words from the control block, one per lane
  lane_ctl_t [NUM_LANES-1:0] lane_ctl;

  // lane outputs gathered before they form the bundle
  logic [NUM_LANES-1:0][COEFF_W-1:0] lane_digit;
  logic [NUM_LANES-1:0]              lane_valid;

  // last strobe only counts together with a valid coefficient
  logic last_in;

  decomp_ctrl u_ctrl (
    .clk       (clk),
    .arst_n    (arst_n),
    .cfg_load  (cfg_load),
    .cfg       (cfg),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .lane_ctl  (lane_ctl),
    .cfg_busy  (cfg_busy),
    .cfg_reject(cfg_reject)
  );

  // every lane sees the same coefficient and picks its own digit
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    elem_decomp u_lane (
      .clk        (clk),
      .arst_n     (arst_n),
      .in_valid   (in_valid),
      .coeff      (coeff),
      .ctl        (lane_ctl[g]),
      .digit      (lane_digit[g]),
      .digit_valid(lane_valid[g])
    );
  end

  assign last_in = in_last & in_valid;

  // last strobe takes the same path length as the digits
  delay_line #(
    .WIDTH (1),
    .CYCLES(DECOMP_LATENCY)
  ) u_last_dly (
    .clk   (clk),
    .arst_n(arst_n),
    .d     (last_in),
    .q     (out_last)
  );

  always_comb begin
    out.digits     = lane_digit;
    out.lane_valid = lane_valid;
  end

  // levels is never below one, so lane 0 is always enabled and
  // its valid marks every output bundle
  assign out_valid = lane_valid[0];

endmodule

`default_nettype wire

/* source/delay_line.sv */
`timescale 1ns/1ps
`default_nettype none

module delay_line #(
  parameter int unsigned WIDTH  = 1,
  parameter int unsigned CYCLES = 1
) (
  input  wire logic             clk,
  input  wire logic             arst_n,
  input  wire logic [WIDTH-1:0] d,
  output logic      [WIDTH-1:0] q
);

  // stage 0 takes the input, the last stage drives the output
  logic [CYCLES-1:0][WIDTH-1:0] stage;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      // every stage is cleared so that strobes passing through start low
      stage <= '0;
    end else begin
      stage[0] <= d;
      // each later stage copies its neighbour, one cycle per stage
      for (int i = 1; i < CYCLES; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  // word that entered CYCLES edges ago
  assign q = stage[CYCLES-1];

endmodule

`default_nettype wire

/* source/elem_decomp.sv */
`timescale 1ns/1ps
`default_nettype none

module elem_decomp (
  input  wire logic                         clk,
  input  wire logic                         arst_n,
  input  wire logic                         in_valid,
  input  wire logic [decomp_pkg::COEFF_W-1:0] coeff,
  input  wire decomp_pkg::lane_ctl_t        ctl,
  output logic      [decomp_pkg::COEFF_W-1:0] digit,
  output logic                              digit_valid
);

  import decomp_pkg::*;

  // first cycle results, before they enter the delay lines
  logic [COEFF_W-1:0] shift_in;
  logic [COEFF_W-1:0] mask_in;
  logic               valid_in;

  // the same words SHIFT_STAGES cycles later
  logic [COEFF_W-1:0] shift_out;
  logic [COEFF_W-1:0] mask_out;
  logic               valid_out;

  // masked digit and its valid, packed together for the last register
  logic [COEFF_W:0] result_in;
  logic [COEFF_W:0] result_out;

  always_comb begin
    // coefficient moved down so that this lane's digit sits at bit 0
    shift_in = coeff >> ctl.shift;
    // all ones in the low bit_cnt bits, a count of zero gives an empty mask
    // a disabled lane gets an empty mask so its digit reads as zero
    if (ctl.enable) begin
      mask_in = {COEFF_W{1'b1}} >> (COEFF_W - ctl.bit_cnt);
    end else begin
      mask_in = '0;
    end
    // enable is sampled together with the coefficient, so a later
    // change of the setting cannot touch words already in the lane
    valid_in = in_valid & ctl.enable;
  end

  delay_line #(
    .WIDTH (COEFF_W),
    .CYCLES(SHIFT_STAGES)
  ) u_shift_dly (
    .clk   (clk),
    .arst_n(arst_n),
    .d     (shift_in),
    .q     (shift_out)
  );

  delay_line #(
    .WIDTH (1),
    .CYCLES(SHIFT_STAGES)
  ) u_valid_dly (
    .clk   (clk),
    .arst_n(arst_n),
    .d     (valid_in),
    .q     (valid_out)
  );

  // mask runs beside the shifted word so the two meet in the same cycle
  delay_line #(
    .WIDTH (COEFF_W),
    .CYCLES(SHIFT_STAGES)
  ) u_mask_dly (
    .clk   (clk),
    .arst_n(arst_n),
    .d     (mask_in),
    .q     (mask_out)
  );

  // the AND is the second operation and gets its own register
  assign result_in = {valid_out, shift_out & mask_out};

  delay_line #(
    .WIDTH (COEFF_W + 1),
    .CYCLES(1)
  ) u_result_dly (
    .clk   (clk),
    .arst_n(arst_n),
    .d     (result_in),
    .q     (result_out)
  );

  // valid rides in the top bit, the digit in the rest
  assign digit_valid = result_out[COEFF_W];
  assign digit       = result_out[COEFF_W-1:0];

endmodule

`default_nettype wire

/* tests/decomp_unit_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module decomp_unit_sva (
  input wire logic                                              clk,
  input wire logic                                              arst_n,
  input wire logic                                              cfg_load,
  input wire logic                                              in_valid,
  input wire logic                                              cfg_busy,
  input wire logic                                              cfg_reject,
  input wire decomp_pkg::decomp_cfg_t                           cfg,
  input wire decomp_pkg::lane_ctl_t [decomp_pkg::NUM_LANES-1:0] lane_ctl
);

  import decomp_pkg::*;

  // enable bits of all lanes side by side
  logic [NUM_LANES-1:0] lane_en;

  // a load in this cycle would be taken under the acceptance rules
  logic load_ok;

  // in_valid of the last DECOMP_LATENCY cycles, bit 0 is the most recent
  logic [DECOMP_LATENCY-1:0] recent_in;

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_en[i] = lane_ctl[i].enable;
    end
    // quiet pipeline, digit width 1 to 32, one to four digits, all digits inside the word
    load_ok = !cfg_busy && !in_valid &&
              (int'(cfg.base_bits) >= 1) && (int'(cfg.base_bits) <= int'(MAX_BASE_BITS)) &&
              (int'(cfg.levels) >= 1) && (int'(cfg.levels) <= int'(NUM_LANES)) &&
              (int'(cfg.base_bits) * int'(cfg.levels) <= int'(COEFF_W));
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      recent_in <= '0;
    end else begin
      recent_in <= {recent_in[DECOMP_LATENCY-2:0], in_valid};
    end
  end

  // a load gives a reject pulse exactly when the rules refuse it
  a_reject_matches_rules: assert property (@(posedge clk) disable iff (!arst_n)
    cfg_load |=> (cfg_reject == !$past(load_ok)))
    else $error("cfg_reject does not match the acceptance rules of the previous load");

  // lane words hold while a coefficient of the last few cycles is still in the pipeline
  a_lanes_stable_in_flight: assert property (@(posedge clk) disable iff (!arst_n)
    !$stable(lane_ctl) |-> (recent_in == '0))
    else $error("lane control changed while coefficients were in flight");

  // exactly the lanes below levels turn on after a load
  a_enable_levels: assert property (@(posedge clk) disable iff (!arst_n)
    cfg_load && load_ok |=>
      (lane_en == ((NUM_LANES'(1) << $past(cfg.levels)) - NUM_LANES'(1))))
    else $error("lane enabled beyond the loaded number of levels");

endmodule

`default_nettype wire

/* tests/decomp_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module decomp_unit_tb;

  import decomp_pkg::*;

  // reset, six tests and their drain phases add up to about 170 cycles
  localparam int TEST_CYCLES    = 170;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;
  localparam int unsigned SEED  = 93;

  // one expected digit bundle with the cycle its coefficient was seen
  typedef struct packed {
    digit_bundle_t bundle;
    logic          last;
    logic [31:0]   cycle;
  } exp_entry_t;

  logic               clk;
  logic               arst_n;
  logic               cfg_load;
  decomp_cfg_t        cfg;
  logic               in_valid;
  logic               in_last;
  logic [COEFF_W-1:0] coeff;
  logic               out_valid;
  logic               out_last;
  digit_bundle_t      out;
  logic               cfg_busy;
  logic               cfg_reject;

  exp_entry_t  exp_q[$];
  logic [63:0] lcg_state;
  int          cycle_cnt = 0;
  int          check_cnt = 0;
  int          error_cnt = 0;
  // setting the reference model decomposes with, changed only by accepted loads
  int          model_base = 16;
  int          model_levels = 4;

  decomp_unit DUT (
    .clk       (clk),
    .arst_n    (arst_n),
    .cfg_load  (cfg_load),
    .cfg       (cfg),
    .in_valid  (in_valid),
    .in_last   (in_last),
    .coeff     (coeff),
    .out_valid (out_valid),
    .out_last  (out_last),
    .out       (out),
    .cfg_busy  (cfg_busy),
    .cfg_reject(cfg_reject)
  );

  bind decomp_ctrl decomp_unit_sva u_sva (
    .clk       (clk),
    .arst_n    (arst_n),
    .cfg_load  (cfg_load),
    .in_valid  (in_valid),
    .cfg_busy  (cfg_busy),
    .cfg_reject(cfg_reject),
    .cfg       (cfg),
    .lane_ctl  (lane_ctl)
  );

  always #4 clk = ~clk;

  // 64-bit LCG, the constants of the usual MMIX generator
  function automatic logic [63:0] lcg_next();
    lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
    return lcg_state;
  endfunction

  // digit i is the coefficient moved down by i digit widths and cut to one width
  function automatic digit_bundle_t ref_decomp(logic [COEFF_W-1:0] c, int base, int levels);
    digit_bundle_t      b;
    logic [COEFF_W-1:0] mask;
    b    = '0;
    mask = (64'd1 << base) - 64'd1;
    for (int i = 0; i < NUM_LANES; i++) begin
      // lanes past levels stay zero with their valid bit low
      if (i < levels) begin
        b.digits[i]     = (c >> (i * base)) & mask;
        b.lane_valid[i] = 1'b1;
      end
    end
    return b;
  endfunction

  function automatic void check_value(string name, logic [63:0] exp, logic [63:0] got);
    check_cnt++;
    assert (got == exp) else begin
      error_cnt++;
      $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
    end
  endfunction

  function automatic void check_cond(logic ok, string what);
    check_cnt++;
    assert (ok) else begin
      error_cnt++;
      $display("[FAIL] %0t %s", $time, what);
    end
  endfunction

  // the cycle counter also guards against a hung run
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles with %0d digit bundles still expected",
               cycle_cnt, exp_q.size());
      $display("summary: %0d checks, %0d errors", check_cnt, error_cnt + 1);
      $display("TB FAILED");
      $finish;
    end
  end

  // outputs and driven inputs are both settled at the falling edge
  always @(negedge clk) begin
    exp_entry_t e;
    logic       overdue;
    if (arst_n) begin
      if (out_valid) begin
        check_cond(exp_q.size() != 0, "out_valid high with no coefficient waiting");
        if (exp_q.size() != 0) begin
          e = exp_q.pop_front();
          for (int i = 0; i < NUM_LANES; i++) begin
            check_value($sformatf("out.digits[%0d]", i), e.bundle.digits[i], out.digits[i]);
          end
          check_value("out.lane_valid", 64'(e.bundle.lane_valid), 64'(out.lane_valid));
          check_value("out_last", 64'(e.last), 64'(out_last));
          check_value("latency", 64'(DECOMP_LATENCY), 64'(cycle_cnt - int'(e.cycle)));
        end
      end else begin
        check_value("out_last", 64'd0, 64'(out_last));
        if (exp_q.size() != 0) begin
          overdue = (cycle_cnt - int'(exp_q[0].cycle)) >= int'(DECOMP_LATENCY);
          check_cond(!overdue, "out_valid low where a digit bundle was due");
          if (overdue) begin
            void'(exp_q.pop_front());
          end
        end
      end
      // a coefficient seen here enters the DUT at the next rising edge
      if (in_valid) begin
        e.bundle = ref_decomp(coeff, model_base, model_levels);
        e.last   = in_last;
        e.cycle  = 32'(cycle_cnt);
        exp_q.push_back(e);
      end
    end
  end

  task automatic reset_dut();
    arst_n = 1'b0;
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
  endtask

  task automatic drive_coeff(logic [COEFF_W-1:0] value, logic last);
    @(posedge clk);
    in_valid <= 1'b1;
    coeff    <= value;
    in_last  <= last;
  endtask

  task automatic drive_idle();
    @(posedge clk);
    in_valid <= 1'b0;
    in_last  <= 1'b0;
  endtask

  // back-to-back random coefficients, the final one carries in_last
  task automatic send_burst(int n);
    for (int i = 0; i < n; i++) begin
      drive_coeff(lcg_next(), i == n - 1);
    end
    drive_idle();
  endtask

  // returns once every bundle came out and the in-flight count is back to zero
  task automatic wait_drain();
    @(negedge clk);
    while (exp_q.size() != 0 || cfg_busy) begin
      @(negedge clk);
    end
  endtask

  // issue a one-cycle load and look at cfg_reject one cycle later
  task automatic load_cfg(int base, int levels, logic expect_accept);
    @(posedge clk);
    cfg_load <= 1'b1;
    cfg      <= '{base_bits: 7'(base), levels: 3'(levels)};
    @(posedge clk);
    cfg_load <= 1'b0;
    @(negedge clk);
    check_value("cfg_reject", 64'(!expect_accept), 64'(cfg_reject));
    if (expect_accept) begin
      model_base   = base;
      model_levels = levels;
    end
  endtask

  task automatic test_reset_state();
    @(negedge clk);
    check_value("out_valid", 64'd0, 64'(out_valid));
    check_value("out_last", 64'd0, 64'(out_last));
    check_value("cfg_busy", 64'd0, 64'(cfg_busy));
    check_value("cfg_reject", 64'd0, 64'(cfg_reject));
    check_value("out.lane_valid", 64'd0, 64'(out.lane_valid));
    // default setting gives four 16-bit digits
    send_burst(20);
    wait_drain();
  endtask

  task automatic test_fixed_latency();
    send_burst(16);
    wait_drain();
  endtask

  task automatic test_reconfig();
    load_cfg(20, 3, 1'b1);
    send_burst(20);
    wait_drain();
  endtask

  task automatic test_invalid_cfg();
    load_cfg(0, 3, 1'b0);
    // one level keeps the product small, so only the width limit refuses it
    load_cfg(40, 1, 1'b0);
    load_cfg(16, 0, 1'b0);
    // 72 bits of digits would run past the coefficient
    load_cfg(24, 3, 1'b0);
    send_burst(8);
    wait_drain();
  endtask

  task automatic test_load_busy();
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      // the load sits in a one-cycle gap of the burst so only cfg_busy can refuse it
      in_valid <= (i != 4);
      coeff    <= lcg_next();
      in_last  <= (i == 9);
      cfg_load <= (i == 4);
      cfg      <= '{base_bits: 7'd8, levels: 3'd4};
      @(negedge clk);
      // the load is sampled at the next rising edge with earlier words in flight
      if (i == 4) begin
        check_value("cfg_busy", 64'd1, 64'(cfg_busy));
      end
      if (i == 5) begin
        check_value("cfg_reject", 64'd1, 64'(cfg_reject));
      end
    end
    drive_idle();
    wait_drain();
  endtask

  task automatic test_sparse();
    load_cfg(12, 4, 1'b1);
    for (int i = 0; i < 8; i++) begin
      drive_coeff(lcg_next(), i == 7);
      // gaps of one to three idle cycles
      repeat ((i % 3) + 1) drive_idle();
    end
    wait_drain();
  endtask

  initial begin
    clk       = 1'b0;
    arst_n    = 1'b0;
    cfg_load  = 1'b0;
    cfg       = '0;
    in_valid  = 1'b0;
    in_last   = 1'b0;
    coeff     = '0;
    lcg_state = 64'(SEED);
    reset_dut();
    test_reset_state();
    test_fixed_latency();
    test_reconfig();
    test_invalid_cfg();
    test_load_busy();
    test_sparse();
    check_cond(exp_q.size() == 0, "digit bundles still expected at the end of the run");
    $display("summary: %0d checks, %0d errors", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
